// ==== bench/mcu_trace_chk.sv ====
// Bound checker for the MCU trace top; AXI4-Lite response stability and ring pointer steps
`timescale 1ns/1ns
`default_nettype none

module mcu_trace_chk (
    input logic                        clk,
    input logic                        rst_i,
    input logic                        awready_i,
    input logic [1:0]                  bresp_i,
    input logic                        bvalid_i,
    input logic                        bready_i,
    input logic [31:0]                 rdata_i,
    input logic [1:0]                  rresp_i,
    input logic                        rvalid_i,
    input logic                        rready_i,
    input logic                        entry_valid_i,
    input mcu_trace_pkg::ring_status_t status_i
);
    import mcu_trace_pkg::*;

    // Write response holds until BREADY
    assert property (@(posedge clk) disable iff (rst_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else $error("BVALID or BRESP changed before BREADY");

    // Read response holds until RREADY
    assert property (@(posedge clk) disable iff (rst_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else $error("RVALID, RDATA or RRESP changed before RREADY");

    // A write handshake raises BVALID next edge, which blocks further writes
    assert property (@(posedge clk) disable iff (rst_i)
        awready_i |=> bvalid_i && !awready_i)
        else $error("BVALID missing or AWREADY high after a write handshake");

    // Write pointer steps by one after each entry, wrapping at the ring depth
    assert property (@(posedge clk) disable iff (rst_i)
        entry_valid_i |=> status_i.wr_ptr == TRACE_PTR_W'($past(status_i.wr_ptr) + 1))
        else $error("ring write pointer did not step by one");

    assert property (@(posedge clk) disable iff (rst_i)
        !entry_valid_i |=> $stable(status_i.wr_ptr))
        else $error("ring write pointer moved without an entry");

endmodule

bind mcu_trace_top mcu_trace_chk u_chk (
    .clk           (clk),
    .rst_i         (rst_i),
    .awready_i     (s_axil_awready_o),
    .bresp_i       (s_axil_bresp_o),
    .bvalid_i      (s_axil_bvalid_o),
    .bready_i      (s_axil_bready_i),
    .rdata_i       (s_axil_rdata_o),
    .rresp_i       (s_axil_rresp_o),
    .rvalid_i      (s_axil_rvalid_o),
    .rready_i      (s_axil_rready_i),
    .entry_valid_i (entry_valid),
    .status_i      (status)
);

`default_nettype wire

// ==== bench/mcu_trace_trace.txt ====
# TEST name | DBG en | PKT insn addr exc ecause irq tval | IDLE cycles | END
# WR addr data exp_resp stall | RD addr exp_data exp_resp stall (hex, counts decimal)
TEST reset_values
RD 00 00000000 0 0
RD 08 00000000 0 0
RD 04 00000010 0 0
RD 0C 00000000 0 0
END

TEST capture_and_read
DBG 1
PKT 00000013 80000000 0 00 0 00000000
PKT 00a00093 80000004 1 02 0 deadbeef
PKT 30200073 80000008 0 0b 1 00001234
IDLE 2
RD 08 00000003 0 0
RD 00 00000002 0 0
RD 10 00000013 0 0
RD 14 80000000 0 0
RD 18 00000000 0 0
RD 1C 00000000 0 0
RD 0C 00000001 0 0
RD 10 00a00093 0 0
RD 14 80000004 0 0
RD 18 00000009 0 0
RD 1C deadbeef 0 0
END

TEST pointer_and_errors
WR 0C 00000002 0 0
RD 0C 00000002 0 0
RD 10 30200073 0 0
RD 14 80000008 0 0
RD 18 0000002e 0 0
RD 1C 00001234 0 0
RD 0C 00000003 0 0
WR 00 00000003 2 0
RD 00 00000002 0 0
WR 08 00000007 2 0
RD 08 00000003 0 0
WR 40 00000005 2 0
RD 0C 00000003 0 0
RD 40 00000000 2 0
WR 0C 00000011 0 0
RD 0C 00000001 0 0
END

TEST ring_wrap
PKT 10000004 8000000c 0 00 0 00000004
PKT 10000005 80000010 0 00 0 00000005
PKT 10000006 80000014 0 00 0 00000006
PKT 10000007 80000018 0 00 0 00000007
PKT 10000008 8000001c 0 00 0 00000008
PKT 10000009 80000020 0 00 0 00000009
PKT 1000000a 80000024 0 00 0 0000000a
PKT 1000000b 80000028 0 00 0 0000000b
PKT 1000000c 8000002c 0 00 0 0000000c
PKT 1000000d 80000030 0 00 0 0000000d
PKT 1000000e 80000034 0 00 0 0000000e
PKT 1000000f 80000038 0 00 0 0000000f
PKT 10000010 8000003c 0 00 0 00000010
PKT 10000011 80000040 1 1f 1 cafe0011
PKT 10000012 80000044 0 05 0 00000012
IDLE 2
RD 00 00000003 0 0
RD 08 00000002 0 0
WR 0C 00000000 0 0
RD 10 10000011 0 0
RD 14 80000040 0 0
RD 18 0000007f 0 0
RD 1C cafe0011 0 0
RD 10 10000012 0 0
RD 1C 00000012 0 0
RD 0C 00000002 0 0
END

TEST debug_locked
DBG 0
PKT 20000000 90000000 0 00 0 00000000
IDLE 2
RD 08 00000002 0 0
RD 10 00000000 2 0
RD 1C 00000000 2 0
RD 0C 00000002 0 0
RD 00 00000003 0 0
DBG 1
RD 10 30200073 0 0
END

TEST backpressure
WR 0C 00000001 0 3
RD 0C 00000001 0 4
RD 18 00000014 0 3
WR 04 00000000 2 2
RD 1C 00000012 0 2
RD 0C 00000002 0 0
END

// ==== bench/tb_mcu_trace.sv ====
// Testbench for the MCU trace block; replays the command trace file against the top level
`timescale 1ns/1ns
`default_nettype none

module tb_mcu_trace;
    import mcu_trace_pkg::*;

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 8;
    // Cycles allowed for one AXI handshake
    localparam int HS_LIMIT     = 20;
    // Watchdog budget per file command
    localparam int CMD_CYCLES   = 50;

    logic                   clk;
    logic                   rst_i;
    logic                   debug_en;
    logic                   trace_valid;
    trace_entry_t           pkt_drv;

    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    int                     cmd_count;
    int                     test_errors;
    int                     total_errors;
    int                     tests_passed;
    int                     tests_failed;
    logic [8*24-1:0]        test_name;

    mcu_trace_top u_dut (
        .clk               (clk),
        .rst_i             (rst_i),
        .debug_en_i        (debug_en),
        .trace_valid_i     (trace_valid),
        .trace_insn_i      (pkt_drv.insn),
        .trace_address_i   (pkt_drv.address),
        .trace_exception_i (pkt_drv.exception),
        .trace_ecause_i    (pkt_drv.ecause),
        .trace_interrupt_i (pkt_drv.interrupt),
        .trace_tval_i      (pkt_drv.tval),
        .s_axil_awaddr_i   (awaddr),
        .s_axil_awvalid_i  (awvalid),
        .s_axil_awready_o  (awready),
        .s_axil_wdata_i    (wdata),
        .s_axil_wstrb_i    (wstrb),
        .s_axil_wvalid_i   (wvalid),
        .s_axil_wready_o   (wready),
        .s_axil_bresp_o    (bresp),
        .s_axil_bvalid_o   (bvalid),
        .s_axil_bready_i   (bready),
        .s_axil_araddr_i   (araddr),
        .s_axil_arvalid_i  (arvalid),
        .s_axil_arready_o  (arready),
        .s_axil_rdata_o    (rdata),
        .s_axil_rresp_o    (rresp),
        .s_axil_rvalid_o   (rvalid),
        .s_axil_rready_i   (rready)
    );

    always #CLK_HALF clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reporting and trace file helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, sig, exp_val, act_val);
        test_errors++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    // Blank lines and lines starting with # carry no command
    function automatic bit is_command(input string line);
        logic [8*8-1:0] tok;
        if ($sscanf(line, "%s", tok) != 1) begin
            return 1'b0;
        end
        return line.getc(0) != "#";
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus drivers, entered and left just after a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic drive_packet(input trace_entry_t pkt);
        pkt_drv     = pkt;
        trace_valid = 1'b1;
        @(negedge clk);
        trace_valid = 1'b0;
    endtask

    task automatic axi_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp, input int stall);
        int         waited;
        logic [1:0] held_resp;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        // Both ready lines are up before the rising edge when no response is pending
        #(CLK_HALF / 2);
        if (awready !== 1'b1) begin
            report_mismatch("s_axil_awready_o", 32'd1, 32'(awready));
        end
        if (wready !== 1'b1) begin
            report_mismatch("s_axil_wready_o", 32'd1, 32'(wready));
        end
        // BVALID one edge after the AW/W handshake marks acceptance
        while (!bvalid && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (bvalid && wready !== 1'b0) begin
            report_mismatch("s_axil_wready_o", 32'd0, 32'(wready));
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) begin
            report_error($sformatf("write to offset %h was never accepted", addr));
        end else begin
            held_resp = bresp;
            if (bresp !== exp_resp) begin
                report_mismatch("s_axil_bresp_o", 32'(exp_resp), 32'(bresp));
            end
            repeat (stall) begin
                @(negedge clk);
                if (!bvalid) begin
                    report_error("BVALID dropped while BREADY was low");
                end
                if (bresp !== held_resp) begin
                    report_mismatch("s_axil_bresp_o", 32'(held_resp), 32'(bresp));
                end
            end
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
            if (bvalid) begin
                report_error("BVALID stayed high after BREADY");
            end
        end
    endtask

    task automatic axi_read(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp, input int stall);
        int          waited;
        logic [31:0] held_data;
        logic [1:0]  held_resp;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        #(CLK_HALF / 2);
        if (arready !== 1'b1) begin
            report_mismatch("s_axil_arready_o", 32'd1, 32'(arready));
        end
        while (!rvalid && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        // No new read is taken while the response is pending
        if (rvalid && arready !== 1'b0) begin
            report_mismatch("s_axil_arready_o", 32'd0, 32'(arready));
        end
        arvalid = 1'b0;
        if (!rvalid) begin
            report_error($sformatf("read at offset %h was never answered", addr));
        end else begin
            held_data = rdata;
            held_resp = rresp;
            if (rdata !== exp_data) begin
                report_mismatch($sformatf("s_axil_rdata_o @%h", addr), exp_data, rdata);
            end
            if (rresp !== exp_resp) begin
                report_mismatch($sformatf("s_axil_rresp_o @%h", addr), 32'(exp_resp),
                                32'(rresp));
            end
            repeat (stall) begin
                @(negedge clk);
                if (!rvalid) begin
                    report_error("RVALID dropped while RREADY was low");
                end
                if (rdata !== held_data) begin
                    report_mismatch("s_axil_rdata_o", held_data, rdata);
                end
                if (rresp !== held_resp) begin
                    report_mismatch("s_axil_rresp_o", 32'(held_resp), 32'(rresp));
                end
            end
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
            if (rvalid) begin
                report_error("RVALID stayed high after RREADY");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Command replay
    //////////////////////////////////////////////////////////////////////

    initial begin
        int              fd;
        int              stall;
        int              count;
        string           line;
        logic [8*8-1:0]  cmd;
        logic [31:0]     f0, f1, f2, f3, f4, f5;
        trace_entry_t    pkt;

        clk          = 1'b0;
        rst_i        = 1'b1;
        debug_en     = 1'b0;
        trace_valid  = 1'b0;
        pkt_drv      = '0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'h0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        cmd_count    = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = '0;

        // First pass only counts commands for the watchdog
        fd = $fopen("bench/mcu_trace_trace.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open bench/mcu_trace_trace.txt");
            total_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (is_command(line)) begin
                    cmd_count++;
                end
            end
            $fclose(fd);
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst_i = 1'b0;

        fd = $fopen("bench/mcu_trace_trace.txt", "r");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (!is_command(line)) begin
                continue;
            end
            void'($sscanf(line, "%s", cmd));
            if (cmd == 64'("TEST")) begin
                void'($sscanf(line, "%s %s", cmd, test_name));
                test_errors = 0;
            end else if (cmd == 64'("DBG")) begin
                void'($sscanf(line, "%s %h", cmd, f0));
                debug_en = f0[0];
            end else if (cmd == 64'("PKT")) begin
                void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, f0, f1, f2, f3, f4, f5));
                pkt.insn      = f0;
                pkt.address   = f1;
                pkt.exception = f2[0];
                pkt.ecause    = f3[4:0];
                pkt.interrupt = f4[0];
                pkt.tval      = f5;
                drive_packet(pkt);
            end else if (cmd == 64'("IDLE")) begin
                void'($sscanf(line, "%s %d", cmd, count));
                repeat (count) @(negedge clk);
            end else if (cmd == 64'("WR")) begin
                void'($sscanf(line, "%s %h %h %h %d", cmd, f0, f1, f2, stall));
                axi_write(f0[AXIL_ADDR_W-1:0], f1, f2[1:0], stall);
            end else if (cmd == 64'("RD")) begin
                void'($sscanf(line, "%s %h %h %h %d", cmd, f0, f1, f2, stall));
                axi_read(f0[AXIL_ADDR_W-1:0], f1, f2[1:0], stall);
            end else if (cmd == 64'("END")) begin
                if (test_errors == 0) begin
                    $display("Test %0s: passed", test_name);
                    tests_passed++;
                end else begin
                    $display("Test %0s: failed with %0d errors", test_name, test_errors);
                    tests_failed++;
                end
                total_errors += test_errors;
                test_errors = 0;
            end else begin
                report_error($sformatf("unknown command %0s in trace file", cmd));
                total_errors += test_errors;
                test_errors = 0;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors == 0 && tests_passed > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog scaled by the number of commands in the file
    initial begin
        wait (cmd_count > 0);
        #(cmd_count * CMD_CYCLES * 2 * CLK_HALF);
        $display("Watchdog expired: the command trace did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mcu_trace_pkg.sv ====
// Shared types, sizes and register map of the MCU trace block; import into each trace module
`default_nettype none

package mcu_trace_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // Ring entries, kept a power of two
    localparam int TRACE_DEPTH = 16;
    localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);

    // AXI4-Lite port widths
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // One retired instruction as reported by the core
    typedef struct packed {
        logic [31:0] insn;
        logic [31:0] address;
        logic        exception;
        logic [4:0]  ecause;
        logic        interrupt;
        logic [31:0] tval;
    } trace_entry_t;

    // Ring state seen by the register reader
    typedef struct packed {
        logic [TRACE_PTR_W-1:0] wr_ptr;
        logic                   wrapped;
    } ring_status_t;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    // Bit 0 wrapped, bit 1 data valid
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_DEPTH  = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_WR_PTR = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_RD_PTR = 8'h0C;

    // Entry at the read pointer, one word per register
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA0  = 8'h10;
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA1  = 8'h14;
    // Exception bit 0, interrupt bit 1, ecause bits 6:2
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA2  = 8'h18;
    // Reading this one steps the read pointer
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA3  = 8'h1C;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== hw/mcu_trace_top.sv ====
// MCU trace block top; connects trace capture, the trace ring and the AXI4-Lite reader
`timescale 1ns/1ns
`default_nettype none

module mcu_trace_top (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  debug_en_i,

    // Core trace port
    input  logic                                  trace_valid_i,
    input  logic [31:0]                           trace_insn_i,
    input  logic [31:0]                           trace_address_i,
    input  logic                                  trace_exception_i,
    input  logic [4:0]                            trace_ecause_i,
    input  logic                                  trace_interrupt_i,
    input  logic [31:0]                           trace_tval_i,

    // Host AXI4-Lite port
    input  logic [mcu_trace_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                                  s_axil_awvalid_i,
    output logic                                  s_axil_awready_o,
    input  logic [mcu_trace_pkg::AXIL_DATA_W-1:0] s_axil_wdata_i,
    input  logic [3:0]                            s_axil_wstrb_i,
    input  logic                                  s_axil_wvalid_i,
    output logic                                  s_axil_wready_o,
    output logic [1:0]                            s_axil_bresp_o,
    output logic                                  s_axil_bvalid_o,
    input  logic                                  s_axil_bready_i,
    input  logic [mcu_trace_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                                  s_axil_arvalid_i,
    output logic                                  s_axil_arready_o,
    output logic [mcu_trace_pkg::AXIL_DATA_W-1:0] s_axil_rdata_o,
    output logic [1:0]                            s_axil_rresp_o,
    output logic                                  s_axil_rvalid_o,
    input  logic                                  s_axil_rready_i
);
    import mcu_trace_pkg::*;

    logic                   entry_valid;
    trace_entry_t           entry;
    ring_status_t           status;
    logic [TRACE_PTR_W-1:0] rd_ptr;
    trace_entry_t           rd_entry;

    // Producer
    trace_capture u_capture (
        .clk               (clk),
        .rst_i             (rst_i),
        .debug_en_i        (debug_en_i),
        .trace_valid_i     (trace_valid_i),
        .trace_insn_i      (trace_insn_i),
        .trace_address_i   (trace_address_i),
        .trace_exception_i (trace_exception_i),
        .trace_ecause_i    (trace_ecause_i),
        .trace_interrupt_i (trace_interrupt_i),
        .trace_tval_i      (trace_tval_i),
        .entry_valid_o     (entry_valid),
        .entry_o           (entry)
    );

    // Buffer
    trace_ring u_ring (
        .clk           (clk),
        .rst_i         (rst_i),
        .entry_valid_i (entry_valid),
        .entry_i       (entry),
        .rd_ptr_i      (rd_ptr),
        .rd_entry_o    (rd_entry),
        .status_o      (status)
    );

    // Consumer
    trace_axil_regs u_regs (
        .clk              (clk),
        .rst_i            (rst_i),
        .debug_en_i       (debug_en_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .status_i         (status),
        .rd_entry_i       (rd_entry),
        .rd_ptr_o         (rd_ptr)
    );

endmodule

`default_nettype wire

// ==== hw/trace_axil_regs.sv ====
// AXI4-Lite register reader for the trace ring; owns the read pointer and applies the debug lock
`timescale 1ns/1ns
`default_nettype none

module trace_axil_regs (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  debug_en_i,

    // Write address and data
    input  logic [mcu_trace_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                                  s_axil_awvalid_i,
    output logic                                  s_axil_awready_o,
    input  logic [mcu_trace_pkg::AXIL_DATA_W-1:0] s_axil_wdata_i,
    input  logic [3:0]                            s_axil_wstrb_i,
    input  logic                                  s_axil_wvalid_i,
    output logic                                  s_axil_wready_o,

    // Write response
    output logic [1:0]                            s_axil_bresp_o,
    output logic                                  s_axil_bvalid_o,
    input  logic                                  s_axil_bready_i,

    // Read address
    input  logic [mcu_trace_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                                  s_axil_arvalid_i,
    output logic                                  s_axil_arready_o,

    // Read data
    output logic [mcu_trace_pkg::AXIL_DATA_W-1:0] s_axil_rdata_o,
    output logic [1:0]                            s_axil_rresp_o,
    output logic                                  s_axil_rvalid_o,
    input  logic                                  s_axil_rready_i,

    // Ring side
    input  mcu_trace_pkg::ring_status_t           status_i,
    input  mcu_trace_pkg::trace_entry_t           rd_entry_i,
    output logic [mcu_trace_pkg::TRACE_PTR_W-1:0] rd_ptr_o
);
    import mcu_trace_pkg::*;

    logic                   wr_hs;
    logic                   rd_hs;
    logic                   wr_rd_ptr;
    logic                   step_rd_ptr;
    logic                   data_valid;
    logic                   data_reg;
    logic [AXIL_DATA_W-1:0] rd_word;
    logic [1:0]             rd_resp;

    //////////////////////////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////////////////////////

    // Address and data taken together, one response outstanding
    assign s_axil_awready_o = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
    assign s_axil_wready_o  = s_axil_awready_o;
    assign wr_hs            = s_axil_awready_o;

    // Only the read pointer is writable
    assign wr_rd_ptr = wr_hs && (s_axil_awaddr_i == REG_RD_PTR);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s_axil_bvalid_o <= 1'b0;
        end else if (wr_hs) begin
            s_axil_bvalid_o <= 1'b1;
        end else if (s_axil_bready_i) begin
            s_axil_bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            s_axil_bresp_o <= (s_axil_awaddr_i == REG_RD_PTR) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read word select
    //////////////////////////////////////////////////////////////////////

    assign data_valid = status_i.wrapped || (status_i.wr_ptr != '0);
    assign data_reg   = (s_axil_araddr_i[AXIL_ADDR_W-1:4] == REG_DATA0[AXIL_ADDR_W-1:4]) &&
                        (s_axil_araddr_i[1:0] == 2'b00);

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (s_axil_araddr_i)
            REG_STATUS: rd_word = AXIL_DATA_W'({data_valid, status_i.wrapped});
            REG_DEPTH:  rd_word = AXIL_DATA_W'(TRACE_DEPTH);
            REG_WR_PTR: rd_word = AXIL_DATA_W'(status_i.wr_ptr);
            REG_RD_PTR: rd_word = AXIL_DATA_W'(rd_ptr_o);
            REG_DATA0:  rd_word = rd_entry_i.insn;
            REG_DATA1:  rd_word = rd_entry_i.address;
            REG_DATA2:  rd_word = AXIL_DATA_W'({rd_entry_i.ecause, rd_entry_i.interrupt,
                                                rd_entry_i.exception});
            REG_DATA3:  rd_word = rd_entry_i.tval;
            default:    rd_resp = RESP_SLVERR;
        endcase
        // Entry contents stay hidden while debug is locked
        if (data_reg && !debug_en_i) begin
            rd_word = '0;
            rd_resp = RESP_SLVERR;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////////////////////////

    assign s_axil_arready_o = !s_axil_rvalid_o;
    assign rd_hs            = s_axil_arvalid_i && s_axil_arready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (rd_hs) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            s_axil_rdata_o <= rd_word;
            s_axil_rresp_o <= rd_resp;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read pointer
    //////////////////////////////////////////////////////////////////////

    // Last data word read moves on to the next entry
    assign step_rd_ptr = rd_hs && (s_axil_araddr_i == REG_DATA3) && debug_en_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ptr_o <= '0;
        end else if (wr_rd_ptr) begin
            // Host write wins over an auto step in the same cycle
            if (s_axil_wstrb_i[0]) begin
                rd_ptr_o <= s_axil_wdata_i[TRACE_PTR_W-1:0];
            end
        end else if (step_rd_ptr) begin
            if (rd_ptr_o == TRACE_PTR_W'(TRACE_DEPTH - 1)) begin
                rd_ptr_o <= '0;
            end else begin
                rd_ptr_o <= rd_ptr_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_capture.sv ====
// Trace capture stage; registers valid core trace packets into ring entries while debug is open
`timescale 1ns/1ns
`default_nettype none

module trace_capture (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        debug_en_i,

    // Core trace port, no back-pressure
    input  logic                        trace_valid_i,
    input  logic [31:0]                 trace_insn_i,
    input  logic [31:0]                 trace_address_i,
    input  logic                        trace_exception_i,
    input  logic [4:0]                  trace_ecause_i,
    input  logic                        trace_interrupt_i,
    input  logic [31:0]                 trace_tval_i,

    // To the ring
    output logic                        entry_valid_o,
    output mcu_trace_pkg::trace_entry_t entry_o
);
    import mcu_trace_pkg::*;

    trace_entry_t pkt;
    logic         take;

    // Packets offered while debug is locked are dropped
    assign take = trace_valid_i && debug_en_i;

    always_comb begin
        pkt.insn      = trace_insn_i;
        pkt.address   = trace_address_i;
        pkt.exception = trace_exception_i;
        pkt.ecause    = trace_ecause_i;
        pkt.interrupt = trace_interrupt_i;
        pkt.tval      = trace_tval_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            entry_valid_o <= 1'b0;
        end else begin
            entry_valid_o <= take;
        end
    end

    // Payload only loads on a taken packet
    always_ff @(posedge clk) begin
        if (take) begin
            entry_o <= pkt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_ring.sv ====
// Circular trace store; writes captured entries in order and serves a combinational read port
`timescale 1ns/1ns
`default_nettype none

module trace_ring (
    input  logic                                      clk,
    input  logic                                      rst_i,

    // Write side from capture
    input  logic                                      entry_valid_i,
    input  mcu_trace_pkg::trace_entry_t               entry_i,

    // Read side for the register reader
    input  logic [mcu_trace_pkg::TRACE_PTR_W-1:0]     rd_ptr_i,
    output mcu_trace_pkg::trace_entry_t               rd_entry_o,
    output mcu_trace_pkg::ring_status_t               status_o
);
    import mcu_trace_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    trace_entry_t           mem [TRACE_DEPTH];
    logic [TRACE_PTR_W-1:0] wr_ptr;
    logic                   wrapped;
    logic                   last_slot;

    assign last_slot = (wr_ptr == TRACE_PTR_W'(TRACE_DEPTH - 1));

    // Oldest entry is overwritten once the ring has wrapped
    always_ff @(posedge clk) begin
        if (entry_valid_i) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write pointer and wrap flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            wrapped <= 1'b0;
        end else if (entry_valid_i) begin
            if (last_slot) begin
                wr_ptr  <= '0;
                // Sticky until reset
                wrapped <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    assign rd_entry_o = mem[rd_ptr_i];

    always_comb begin
        status_o.wr_ptr  = wr_ptr;
        status_o.wrapped = wrapped;
    end

endmodule

`default_nettype wire

// ==== mcu_trace.f ====
hw/mcu_trace_pkg.sv
hw/trace_capture.sv
hw/trace_ring.sv
hw/trace_axil_regs.sv
hw/mcu_trace_top.sv
bench/mcu_trace_chk.sv
bench/tb_mcu_trace.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MCU trace testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f mcu_trace.f \
    --top-module tb_mcu_trace \
    -o sim_mcu_trace

./obj_dir/sim_mcu_trace 2>&1 | tee sim.log

if grep -qxF '** PASS **' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
